//--- filelist.f
logic/midi_pkg.sv
logic/midi_bit_timer.sv
logic/midi_uart_ctrl.sv
logic/midi_rx_shifter.sv
logic/midi_tx_shifter.sv
logic/midi_status_tracker.sv
logic/midi_uart_top.sv
testbench/midi_uart_tb.sv

//--- logic/midi_bit_timer.sv
`timescale 1ns/1ns

module midi_bit_timer
    import midi_pkg::*;
(
    input  logic reg_clk,
    input  logic reset_reg_N,
    input  logic restart,
    output logic tick
);

    localparam logic [half_bit_cnt_w-1:0] cnt_last = half_bit_cnt_w'(half_bit_clks - 1);

    logic [half_bit_cnt_w-1:0] count;

    // free running between restarts
    always_ff @(posedge reg_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;
        end else if (count == cnt_last) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // one cycle per half bit, first one 400 clocks after restart
    assign tick = (count == cnt_last) && !restart;

endmodule

//--- logic/midi_pkg.sv
package midi_pkg;

    // 25 MHz reg_clk, 31250 baud: 800 clocks per bit
    localparam int unsigned half_bit_clks = 400;
    localparam int unsigned half_bit_cnt_w = $clog2(half_bit_clks);

    // half-bit slots of one frame
    localparam int unsigned slot_w = 5;
    localparam logic [slot_w-1:0] rx_first_sample = 5'd3;
    localparam logic [slot_w-1:0] rx_last_slot = 5'd19;
    localparam logic [slot_w-1:0] tx_last_slot = 5'd19;

    // start, 8 data, stop
    localparam logic [3:0] tx_stop_sel = 4'd9;

    // sysex end, never a running status
    localparam logic [7:0] midi_eox = 8'hF7;

    typedef struct packed {
        logic       status_flag;
        logic [2:0] msg_kind;
        logic [3:0] channel;
    } midi_status_view_t;

    typedef struct packed {
        logic       status_flag;
        logic [6:0] value;
    } midi_data_view_t;

    // one MIDI byte, seen as status or as data
    typedef union packed {
        midi_status_view_t status;
        midi_data_view_t   data;
    } midi_byte_u;

    // controller to receive shifter
    typedef struct packed {
        logic       sample;
        logic [2:0] bit_index;
        logic       stop_check;
    } rx_strobe_t;

    // controller to transmit shifter
    // bit_sel 0 = start, 1..8 = data bits 0..7, 9 = stop
    typedef struct packed {
        logic       load;
        logic       drive;
        logic [3:0] bit_sel;
    } tx_step_t;

    typedef struct packed {
        midi_byte_u data;
        midi_byte_u status;
        logic [7:0] byte_nr;
    } midi_rx_event_t;

endpackage

//--- logic/midi_rx_shifter.sv
`timescale 1ns/1ns

module midi_rx_shifter
    import midi_pkg::*;
(
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic       rxd,
    input  rx_strobe_t rx_strobe,
    output logic       rx_line,
    output logic       byte_done,
    output logic [7:0] rx_byte,
    output logic       framing_error
);

    logic [1:0] rxd_sync;
    logic [1:0] rxd_hist;
    logic [7:0] shift_byte;

    // two-flop synchroniser plus two samples of history
    always_ff @(posedge reg_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            rxd_sync <= 2'b11;
            rxd_hist <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rxd_hist <= {rxd_hist[0], rxd_sync[1]};
        end
    end

    // low only after three low samples in a row
    assign rx_line = rxd_sync[1] | rxd_hist[0] | rxd_hist[1];

    always_ff @(posedge reg_clk) begin
        if (rx_strobe.sample) begin
            shift_byte[rx_strobe.bit_index] <= rx_line;
        end
    end

    // stable from the stop check until the next frame's bit 0
    assign rx_byte = shift_byte;

    always_ff @(posedge reg_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            byte_done <= 1'b0;
            framing_error <= 1'b0;
        end else begin
            byte_done <= rx_strobe.stop_check && rx_line;
            // stop bit must be high
            framing_error <= rx_strobe.stop_check && !rx_line;
        end
    end

endmodule

//--- logic/midi_status_tracker.sv
`timescale 1ns/1ns

module midi_status_tracker
    import midi_pkg::*;
(
    input  logic           reg_clk,
    input  logic           reset_reg_N,
    input  logic           byte_done,
    input  logic [7:0]     rx_byte,
    output logic           rx_event_valid,
    output midi_rx_event_t rx_event
);

    midi_byte_u in_byte;
    logic       is_status;

    midi_byte_u data_q;
    midi_byte_u status_q;
    logic [7:0] byte_nr_q;

    assign in_byte = rx_byte;

    // F7 has the status flag but keeps the running status
    assign is_status = in_byte.status.status_flag && (in_byte != midi_eox);

    always_ff @(posedge reg_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            status_q <= '0;
            byte_nr_q <= '0;
            rx_event_valid <= 1'b0;
        end else begin
            rx_event_valid <= byte_done;
            if (byte_done) begin
                if (is_status) begin
                    status_q <= in_byte;
                    byte_nr_q <= '0;
                end else begin
                    // wraps at 256
                    byte_nr_q <= byte_nr_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge reg_clk) begin
        if (byte_done) begin
            data_q <= in_byte;
        end
    end

    assign rx_event.data = data_q;
    assign rx_event.status = status_q;
    assign rx_event.byte_nr = byte_nr_q;

endmodule

//--- logic/midi_tx_shifter.sv
`timescale 1ns/1ns

module midi_tx_shifter
    import midi_pkg::*;
(
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic [7:0] out_data,
    input  tx_step_t   tx_step,
    output logic       txd
);

    logic [7:0] tx_buf;
    logic       data_bit;

    always_ff @(posedge reg_clk) begin
        if (tx_step.load) begin
            tx_buf <= out_data;
        end
    end

    // bit_sel 1..8 wraps onto buffer index 0..7
    assign data_bit = tx_buf[tx_step.bit_sel[2:0] - 3'd1];

    always_ff @(posedge reg_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            txd <= 1'b1;
        end else if (tx_step.drive) begin
            if (tx_step.bit_sel == '0) begin
                txd <= 1'b0;
            end else if (tx_step.bit_sel == tx_stop_sel) begin
                txd <= 1'b1;
            end else begin
                txd <= data_bit;
            end
        end
    end

endmodule

//--- logic/midi_uart_ctrl.sv
`timescale 1ns/1ns

module midi_uart_ctrl
    import midi_pkg::*;
(
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic       rx_line,
    input  logic       rx_tick,
    input  logic       tx_tick,
    input  logic       send_byte,
    output logic       rx_timer_restart,
    output logic       tx_timer_restart,
    output rx_strobe_t rx_strobe,
    output tx_step_t   tx_step,
    output logic       out_ready
);

    logic              rx_busy;
    logic [slot_w-1:0] rx_slot;
    logic [slot_w-1:0] rx_next;
    logic [slot_w-1:0] rx_bit_offset;

    logic              tx_busy;
    logic [slot_w-1:0] tx_slot;
    logic [slot_w-1:0] tx_next;

    // start bit seen while idle
    assign rx_timer_restart = !rx_busy && !rx_line;
    assign rx_next = rx_slot + 1'b1;
    // odd slots 3..17 map to data bits 0..7
    assign rx_bit_offset = rx_next - rx_first_sample;

    always_ff @(posedge reg_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            rx_busy <= 1'b0;
            rx_slot <= '0;
            rx_strobe <= '0;
        end else begin
            rx_strobe.sample <= 1'b0;
            rx_strobe.stop_check <= 1'b0;
            if (rx_timer_restart) begin
                rx_busy <= 1'b1;
                rx_slot <= '0;
            end else if (rx_busy && rx_tick) begin
                rx_slot <= rx_next;
                rx_strobe.bit_index <= rx_bit_offset[3:1];
                if (rx_next == rx_last_slot) begin
                    // middle of the stop bit, frame done
                    rx_strobe.stop_check <= 1'b1;
                    rx_busy <= 1'b0;
                end else if (rx_next[0] && rx_next >= rx_first_sample) begin
                    rx_strobe.sample <= 1'b1;
                end
            end
        end
    end

    // transmit side only accepts while idle
    assign out_ready = !tx_busy;
    assign tx_timer_restart = send_byte && !tx_busy;
    assign tx_next = tx_slot + 1'b1;

    always_ff @(posedge reg_clk or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            tx_busy <= 1'b0;
            tx_slot <= '0;
            tx_step <= '0;
        end else begin
            tx_step.load <= 1'b0;
            tx_step.drive <= 1'b0;
            if (tx_timer_restart) begin
                // latch data and drive the start bit at once
                tx_busy <= 1'b1;
                tx_slot <= '0;
                tx_step.load <= 1'b1;
                tx_step.drive <= 1'b1;
                tx_step.bit_sel <= '0;
            end else if (tx_busy && tx_tick) begin
                if (tx_slot == tx_last_slot) begin
                    tx_busy <= 1'b0;
                end else begin
                    tx_slot <= tx_next;
                    // every second tick starts the next bit
                    if (!tx_next[0]) begin
                        tx_step.drive <= 1'b1;
                        tx_step.bit_sel <= tx_next[4:1];
                    end
                end
            end
        end
    end

endmodule

//--- logic/midi_uart_top.sv
`timescale 1ns/1ns

module midi_uart_top
    import midi_pkg::*;
(
    input  logic           reg_clk,
    input  logic           reset_reg_N,
    input  logic           midi_rxd,
    input  logic           midi_send_byte,
    input  logic [7:0]     midi_out_data,
    output logic           midi_txd,
    output logic           midi_out_ready,
    output logic           rx_event_valid,
    output midi_rx_event_t rx_event,
    output logic           framing_error
);

    logic       rx_line;
    logic       rx_tick;
    logic       tx_tick;
    logic       rx_timer_restart;
    logic       tx_timer_restart;
    rx_strobe_t rx_strobe;
    tx_step_t   tx_step;
    logic       byte_done;
    logic [7:0] rx_byte;

    midi_uart_ctrl u_ctrl (
        .reg_clk          (reg_clk),
        .reset_reg_N      (reset_reg_N),
        .rx_line          (rx_line),
        .rx_tick          (rx_tick),
        .tx_tick          (tx_tick),
        .send_byte        (midi_send_byte),
        .rx_timer_restart (rx_timer_restart),
        .tx_timer_restart (tx_timer_restart),
        .rx_strobe        (rx_strobe),
        .tx_step          (tx_step),
        .out_ready        (midi_out_ready)
    );

    // separate timers so receive and transmit run independently
    midi_bit_timer u_rx_timer (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .restart     (rx_timer_restart),
        .tick        (rx_tick)
    );

    midi_bit_timer u_tx_timer (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .restart     (tx_timer_restart),
        .tick        (tx_tick)
    );

    midi_rx_shifter u_rx_shifter (
        .reg_clk       (reg_clk),
        .reset_reg_N   (reset_reg_N),
        .rxd           (midi_rxd),
        .rx_strobe     (rx_strobe),
        .rx_line       (rx_line),
        .byte_done     (byte_done),
        .rx_byte       (rx_byte),
        .framing_error (framing_error)
    );

    midi_tx_shifter u_tx_shifter (
        .reg_clk     (reg_clk),
        .reset_reg_N (reset_reg_N),
        .out_data    (midi_out_data),
        .tx_step     (tx_step),
        .txd         (midi_txd)
    );

    midi_status_tracker u_tracker (
        .reg_clk        (reg_clk),
        .reset_reg_N    (reset_reg_N),
        .byte_done      (byte_done),
        .rx_byte        (rx_byte),
        .rx_event_valid (rx_event_valid),
        .rx_event       (rx_event)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the MIDI UART testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -j 0 --top-module midi_uart_tb -f filelist.f \
    -o midi_uart_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/midi_uart_sim > sim.log 2>&1
cat sim.log

grep -qx "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/midi_uart_tb.sv
`timescale 1ns/1ns

module midi_uart_tb
    import midi_pkg::*;
();

    localparam int bit_clks = 800;
    localparam int frame_clks = 10 * bit_clks;
    localparam int total_frames = 60;
    // frames x 8000 clocks x 40 ns, doubled, plus a margin
    localparam longint watchdog_ns = longint'(total_frames) * 8000 * 40 * 2 + 1000000;
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    logic           reg_clk;
    logic           reset_reg_N;
    logic           midi_rxd;
    logic           midi_send_byte;
    logic [7:0]     midi_out_data;
    logic           midi_txd;
    logic           midi_out_ready;
    logic           rx_event_valid;
    midi_rx_event_t rx_event;
    logic           framing_error;

    int             value_errors;
    int             other_errors;
    int             framing_pending;
    logic [31:0]    lfsr_state;

    // running status model
    midi_byte_u     model_status;
    logic [7:0]     model_count;
    midi_rx_event_t rx_expected[$];
    midi_rx_event_t rx_head;
    logic [7:0]     tx_expected[$];

    midi_uart_top dut (
        .reg_clk        (reg_clk),
        .reset_reg_N    (reset_reg_N),
        .midi_rxd       (midi_rxd),
        .midi_send_byte (midi_send_byte),
        .midi_out_data  (midi_out_data),
        .midi_txd       (midi_txd),
        .midi_out_ready (midi_out_ready),
        .rx_event_valid (rx_event_valid),
        .rx_event       (rx_event),
        .framing_error  (framing_error)
    );

    always #20 reg_clk = ~reg_clk;

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("error at %0t ns: %s is %02h, expected %02h", $time, name, got, expected);
        end
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ lfsr_taps;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        int         i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // first bit picks status or data, seven more fill the rest
    function automatic logic [7:0] random_midi_byte();
        logic [7:0] kind;
        logic [7:0] low;
        kind = take_bits(1);
        low = take_bits(7);
        return {kind[0], low[6:0]};
    endfunction

    task automatic expect_rx(input logic [7:0] b);
        midi_rx_event_t e;
        // F7 never becomes the running status
        if (b[7] && b != 8'hF7) begin
            model_status = b;
            model_count = 8'd0;
        end else begin
            model_count = model_count + 8'd1;
        end
        e.data = b;
        e.status = model_status;
        e.byte_nr = model_count;
        rx_expected.push_back(e);
    endtask

    // start, eight data bits LSB first, stop
    task automatic drive_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            midi_rxd = bits[i];
            repeat (bit_clks) @(negedge reg_clk);
        end
    endtask

    task automatic receive_frame(input logic [7:0] b);
        expect_rx(b);
        drive_frame(b, 1'b1);
    endtask

    task automatic wait_rx_drain();
        int waited;
        waited = 0;
        while (rx_expected.size() != 0 && waited < frame_clks + 1000) begin
            @(negedge reg_clk);
            waited++;
        end
        if (rx_expected.size() != 0) begin
            report_failure($sformatf("%0d receive events never arrived", rx_expected.size()));
            rx_expected.delete();
        end
    endtask

    task automatic wait_tx_drain();
        int waited;
        waited = 0;
        while (tx_expected.size() != 0 && waited < frame_clks + 1000) begin
            @(negedge reg_clk);
            waited++;
        end
        if (tx_expected.size() != 0) begin
            report_failure($sformatf("%0d bytes never appeared on midi_txd", tx_expected.size()));
            tx_expected.delete();
        end
    endtask

    task automatic send_tx(input logic [7:0] b, input logic interfere);
        int waited;
        waited = 0;
        while (!midi_out_ready && waited < frame_clks + 100) begin
            @(negedge reg_clk);
            waited++;
        end
        if (!midi_out_ready) begin
            report_failure("midi_out_ready never rose before a send");
            return;
        end
        tx_expected.push_back(b);
        midi_out_data = b;
        midi_send_byte = 1'b1;
        @(negedge reg_clk);
        midi_send_byte = 1'b0;
        check_value("midi_out_ready", 8'(midi_out_ready), 8'h00);
        waited = 1;
        if (interfere) begin
            // strobe while busy, must be ignored
            repeat (3000) @(negedge reg_clk);
            midi_out_data = ~b;
            midi_send_byte = 1'b1;
            @(negedge reg_clk);
            midi_send_byte = 1'b0;
            waited += 3001;
        end
        while (!midi_out_ready && waited < frame_clks + 100) begin
            @(negedge reg_clk);
            waited++;
        end
        if (!midi_out_ready) begin
            report_failure("midi_out_ready stayed low after the frame");
        end else if (waited < frame_clks - 4) begin
            report_failure("midi_out_ready rose before the frame ended");
        end
    endtask

    always @(negedge reg_clk) begin
        if (reset_reg_N && rx_event_valid) begin
            if (rx_expected.size() == 0) begin
                report_failure("rx_event_valid with no frame pending");
            end else begin
                rx_head = rx_expected.pop_front();
                check_value("rx_event.data", rx_event.data, rx_head.data);
                check_value("rx_event.status", rx_event.status, rx_head.status);
                check_value("rx_event.byte_nr", rx_event.byte_nr, rx_head.byte_nr);
            end
        end
        if (reset_reg_N && framing_error) begin
            if (framing_pending == 0) begin
                report_failure("framing_error without a bad stop bit");
            end else begin
                framing_pending--;
            end
        end
    end

    // rebuilds each frame on midi_txd from the falling start edge
    initial begin : tx_monitor
        int         b;
        int         c;
        logic [9:0] frame;
        logic       first_val;
        logic       held;
        logic [7:0] exp_b;
        forever begin
            @(negedge midi_txd);
            for (b = 0; b < 10; b++) begin
                held = 1'b1;
                for (c = 0; c < bit_clks; c++) begin
                    @(negedge reg_clk);
                    if (c == 0) begin
                        first_val = midi_txd;
                    end else if (midi_txd !== first_val) begin
                        held = 1'b0;
                    end
                    if (c == bit_clks / 2 - 1) begin
                        frame[b] = midi_txd;
                    end
                end
                if (!held) begin
                    report_failure($sformatf("midi_txd changed inside bit %0d", b));
                end
            end
            if (tx_expected.size() == 0) begin
                report_failure("frame on midi_txd with no byte pending");
            end else begin
                exp_b = tx_expected.pop_front();
                check_value("midi_txd start bit", 8'(frame[0]), 8'h00);
                check_value("midi_txd data", frame[8:1], exp_b);
                check_value("midi_txd stop bit", 8'(frame[9]), 8'h01);
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        report_failure("watchdog expired before the tests finished");
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main_sequence
        int         k;
        logic [7:0] b;
        reg_clk = 1'b0;
        reset_reg_N = 1'b0;
        midi_rxd = 1'b1;
        midi_send_byte = 1'b0;
        midi_out_data = 8'h00;
        value_errors = 0;
        other_errors = 0;
        framing_pending = 0;
        lfsr_state = 32'h3666;
        model_status = '0;
        model_count = 8'd0;
        repeat (4) @(negedge reg_clk);
        reset_reg_N = 1'b1;
        @(negedge reg_clk);
        check_value("midi_out_ready", 8'(midi_out_ready), 8'h01);
        check_value("midi_txd", 8'(midi_txd), 8'h01);
        check_value("rx_event_valid", 8'(rx_event_valid), 8'h00);
        check_value("framing_error", 8'(framing_error), 8'h00);

        // receive data and running status, F7 once in the middle
        for (k = 0; k < 24; k++) begin
            if (k == 12) begin
                b = 8'hF7;
            end else begin
                b = random_midi_byte();
            end
            receive_frame(b);
        end
        wait_rx_drain();

        // short low pulses on the idle line
        repeat (100) @(negedge reg_clk);
        midi_rxd = 1'b0;
        @(negedge reg_clk);
        midi_rxd = 1'b1;
        repeat (100) @(negedge reg_clk);
        midi_rxd = 1'b0;
        repeat (2) @(negedge reg_clk);
        midi_rxd = 1'b1;
        repeat (frame_clks) @(negedge reg_clk);

        framing_pending = 1;
        drive_frame(random_midi_byte(), 1'b0);
        midi_rxd = 1'b1;
        if (framing_pending != 0) begin
            report_failure("no framing_error for a low stop bit");
            framing_pending = 0;
        end
        // line still low after the stop check, receiver re-arms and reads all ones
        expect_rx(8'hFF);
        wait_rx_drain();

        for (k = 0; k < 16; k++) begin
            send_tx(take_bits(8), k % 4 == 3);
        end
        wait_tx_drain();

        // full duplex
        fork
            begin : rx_stream
                int j;
                for (j = 0; j < 8; j++) begin
                    receive_frame(random_midi_byte());
                end
            end
            begin : tx_stream
                int j;
                for (j = 0; j < 8; j++) begin
                    send_tx(take_bits(8), 1'b0);
                end
            end
        join
        wait_rx_drain();
        wait_tx_drain();

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
